// ==== LcdPkg.sv ====
// LCD driver package with scan states, glass pin map, bias levels and timing constants
`default_nettype none
package LcdPkg;

	// Glass geometry
	localparam int NumPins     = 36;         // Pins 1 to 36
	localparam int NumComs     = 4;          // 4-mux glass
	localparam int NumSegPins  = 32;         // All pins that are not COMs
	localparam int NumChars    = 8;          // Character 0 is rightmost
	localparam int BitmapWidth = 15;         // Segment order pnmlkjihgfedcba

	// PWM and timing
	localparam int PwmPhases          = 3;  // One phase per third of supply
	localparam int PwmPhaseWidth      = $clog2(PwmPhases);
	localparam int DefaultClockHz     = 10_000_000;
	localparam int DefaultChangeComUs = 10;

	// H states first, then the same COM order with inverted polarity
	typedef enum logic [2:0] {
		Com0H, Com1H, Com2H, Com3H,
		Com0L, Com1L, Com2L, Com3L
	} ScanState;

	typedef logic [1:0] BiasLevel;           // 0 = 0 V, 3 = full supply

	// Levels in H states; L states use the bitwise inverse (3 - level)
	localparam BiasLevel BiasComActiveH = 2'd3;
	localparam BiasLevel BiasComIdleH   = 2'd1;
	localparam BiasLevel BiasSegLitH    = 2'd0;
	localparam BiasLevel BiasSegDarkH   = 2'd2;

	// Glass pin of COM0 to COM3
	localparam int ComPins [NumComs] = '{19, 36, 18, 1};

	// Segment pins, list index s drives character s/4
	localparam int SegPins [NumSegPins] = '{
		 2,  3,  4,  5,  6,  7,  8,  9,
		10, 11, 12, 13, 14, 15, 16, 17,
		20, 21, 22, 23, 24, 25, 26, 27,
		28, 29, 30, 31, 32, 33, 34, 35
	};

	// Clocks per strobe period, 64-bit product to avoid overflow
	function automatic int StrobeCyclesOf(input int ClockHz, input int PeriodUs);
		return int'((longint'(ClockHz) * longint'(PeriodUs)) / 64'd1_000_000);
	endfunction

endpackage
`default_nettype wire

// ==== LcdLevelIf.sv ====
// Bundle of the four PWM bias level wires between the PWM generator and the scanner
`default_nettype none
interface LcdLevelIf;

	logic Level0;                            // 0 V, always low
	logic Level1;                            // 1/3 duty
	logic Level2;                            // 2/3 duty
	logic Level3;                            // Full supply, always high

	modport source (
		output Level0,
		output Level1,
		output Level2,
		output Level3
	);

	modport sink (
		input  Level0,
		input  Level1,
		input  Level2,
		input  Level3
	);

endinterface
`default_nettype wire

// ==== StrobeGenerator.sv ====
// Strobe generator giving a one-clock pulse every PeriodUs microseconds
`default_nettype none
module StrobeGenerator import LcdPkg::*; #(
	parameter int ClockHz  = DefaultClockHz,
	parameter int PeriodUs = DefaultChangeComUs
)(
	input  logic Clock,
	input  logic Reset,
	output logic Strobe_o
);

	localparam int StrobeCycles = StrobeCyclesOf(ClockHz, PeriodUs);
	localparam int CountWidth   = (StrobeCycles > 1) ? $clog2(StrobeCycles) : 1;

	logic [CountWidth-1:0] Count;            // Clocks left until next pulse
	logic                  CountZero;

	assign CountZero = (Count == '0);

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Count    <= CountWidth'(StrobeCycles - 1); // First pulse S clocks after reset
			Strobe_o <= 1'b0;
		end else begin
			Strobe_o <= CountZero;               // Registered, so one clock wide
			if (CountZero)
				Count <= CountWidth'(StrobeCycles - 1); // Reload for next period
			else
				Count <= Count - 1'b1;
		end
	end

	initial begin
		if (StrobeCycles < 1)
			$error("Strobe period shorter than one clock");
	end

endmodule
`default_nettype wire

// ==== LcdPwm.sv ====
// Three-phase PWM generator for the 0, 1/3, 2/3 and full LCD bias levels
`default_nettype none
module LcdPwm import LcdPkg::*; (
	input  logic      Clock,
	input  logic      Reset,
	LcdLevelIf.source Levels_o
);

	logic [PwmPhaseWidth-1:0] Phase;         // Runs 0, 1, 2, 0 ...
	logic [PwmPhaseWidth-1:0] PhaseNext;
	logic                     Level1Q;
	logic                     Level2Q;

	always_comb begin
		if (Phase == PwmPhaseWidth'(PwmPhases - 1))
			PhaseNext = '0;                      // Wrap after last phase
		else
			PhaseNext = Phase + 1'b1;
	end

	// Level k is high during phases 0 to k-1
	// Registered from the next phase so the RC filters see clean edges
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Phase   <= '0;
			Level1Q <= 1'b1;                     // Matches phase 0
			Level2Q <= 1'b1;
		end else begin
			Phase   <= PhaseNext;
			Level1Q <= (PhaseNext < PwmPhaseWidth'(1));
			Level2Q <= (PhaseNext < PwmPhaseWidth'(2));
		end
	end

	assign Levels_o.Level0 = 1'b0;          // 0/3 duty
	assign Levels_o.Level1 = Level1Q;       // 1/3 duty
	assign Levels_o.Level2 = Level2Q;       // 2/3 duty
	assign Levels_o.Level3 = 1'b1;          // 3/3 duty

endmodule
`default_nettype wire

// ==== LcdScanner.sv ====
// COM scan FSM with per-pin bias selection and PWM level mux onto the glass pins
`default_nettype none
module LcdScanner import LcdPkg::*; (
	input  logic                                   Clock,
	input  logic                                   Reset,
	input  logic                                   ChangeState_i,
	input  logic [NumChars-1:0][BitmapWidth-1:0] Bitmap_i,
	LcdLevelIf.sink                                Levels_i,
	output logic [NumPins:1]                       Pin_o
);

	ScanState    State;                      // Current COM and polarity
	logic [1:0]  ComIdx;                     // Active COM number
	logic        PolarityLow;                // L half of the frame
	logic [3:0]  LevelBus;                   // PWM wires indexed by bias level
	BiasLevel    PinLevel [NumPins:1];       // Bias wanted on each pin

	// FSM, one step per strobe, wraps from Com3L to Com0H
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			State <= Com0H;
		else if (ChangeState_i)
			State <= ScanState'(State + 3'd1);
	end

	assign ComIdx      = State[1:0];         // Low bits pick the COM
	assign PolarityLow = State[2];           // High bit picks H or L

	assign LevelBus = {
		Levels_i.Level3,
		Levels_i.Level2,
		Levels_i.Level1,
		Levels_i.Level0
	};

	// Bias rule
	// H: active COM 3, idle COM 1, lit SEG 0, dark SEG 2
	// L: every level inverted, so each pin averages to zero DC over a frame
	always_comb begin : BiasSelect
		logic [3:0] BitIdx;
		logic       Lit;
		BiasLevel   HLevel;

		PinLevel = '{default: BiasComIdleH}; // Every pin overwritten below
		BitIdx   = '0;
		Lit      = 1'b0;
		HLevel   = BiasComIdleH;

		// COM pins
		for (int c = 0; c < NumComs; c++) begin
			HLevel = (ComIdx == 2'(c)) ? BiasComActiveH : BiasComIdleH;
			PinLevel[ComPins[c]] = PolarityLow ? ~HLevel : HLevel;
		end

		// Segment pins, slot s of character s/4 shows bit 4*COM + s%4
		for (int s = 0; s < NumSegPins; s++) begin
			BitIdx = {ComIdx, 2'(s % 4)};
			if (BitIdx == 4'd15)
				Lit = 1'b0;                      // No bit 15, slot stays dark
			else
				Lit = Bitmap_i[s / 4][BitIdx];
			HLevel = Lit ? BiasSegLitH : BiasSegDarkH;
			PinLevel[SegPins[s]] = PolarityLow ? ~HLevel : HLevel;
		end
	end

	// Output mux, each pin follows the PWM wire of its level
	always_comb begin
		for (int n = 1; n <= NumPins; n++) begin
			Pin_o[n] = LevelBus[PinLevel[n]];
		end
	end

endmodule
`default_nettype wire

// ==== Lcd.sv ====
// Top level of the 4-mux 15-segment LCD driver with eight characters on 36 glass pins
`default_nettype none
module Lcd import LcdPkg::*; #(
	parameter int ClockHz     = DefaultClockHz,
	parameter int ChangeComUs = DefaultChangeComUs
)(
	input  logic                   Clock,
	input  logic                   Reset,

	// Leftmost character first, segment order pnmlkjihgfedcba
	input  logic [BitmapWidth-1:0] Bitmap7_i,
	input  logic [BitmapWidth-1:0] Bitmap6_i,
	input  logic [BitmapWidth-1:0] Bitmap5_i,
	input  logic [BitmapWidth-1:0] Bitmap4_i,
	input  logic [BitmapWidth-1:0] Bitmap3_i,
	input  logic [BitmapWidth-1:0] Bitmap2_i,
	input  logic [BitmapWidth-1:0] Bitmap1_i,
	input  logic [BitmapWidth-1:0] Bitmap0_i,

	// Each pin needs an external RC filter to smooth the PWM
	output logic [NumPins:1]       Pin_o
);

	logic ChangeState;                       // One clock per COM step

	LcdLevelIf Levels ();                    // Bias level wires

	StrobeGenerator #(
		.ClockHz  (ClockHz),
		.PeriodUs (ChangeComUs)
	) StrobeGen (
		.Clock    (Clock),
		.Reset    (Reset),
		.Strobe_o (ChangeState)
	);

	LcdPwm Pwm (
		.Clock    (Clock),
		.Reset    (Reset),
		.Levels_o (Levels)
	);

	LcdScanner Scanner (
		.Clock         (Clock),
		.Reset         (Reset),
		.ChangeState_i (ChangeState),
		.Bitmap_i      ({Bitmap7_i, Bitmap6_i, Bitmap5_i, Bitmap4_i,
		                 Bitmap3_i, Bitmap2_i, Bitmap1_i, Bitmap0_i}), // Char 0 at index 0
		.Levels_i      (Levels),
		.Pin_o         (Pin_o)
	);

endmodule
`default_nettype wire

// ==== Lcd_sva.sv ====
// Bound assertions on the LCD scan FSM and the constant bias level wires
`default_nettype none
module LcdScannerSva import LcdPkg::*; (
	input logic       Clock,
	input logic       Reset,
	input logic       ChangeState_i,
	input ScanState   State,
	input logic [3:0] LevelBus
);

	// Scan order from the frame layout
	function automatic ScanState nextStateOf(input ScanState S);
		case (S)
			Com0H:   return Com1H;
			Com1H:   return Com2H;
			Com2H:   return Com3H;
			Com3H:   return Com0L;            // Same COMs again, inverted
			Com0L:   return Com1L;
			Com1L:   return Com2L;
			Com2L:   return Com3L;
			default: return Com0H;            // Frame wraps
		endcase
	endfunction

	// 0 V wire never pulses
	LevelZeroLow: assert property (@(posedge Clock) disable iff (!Reset)
		!LevelBus[0])
		else $error("Level0 driven high");

	// Full supply wire never drops
	LevelFullHigh: assert property (@(posedge Clock) disable iff (!Reset)
		LevelBus[3])
		else $error("Level3 driven low");

	// Strobe is a single clock wide
	StrobeSingle: assert property (@(posedge Clock) disable iff (!Reset)
		ChangeState_i |=> !ChangeState_i)
		else $error("ChangeState_i high for two cycles");

	// One step per strobe with Com3L wrapping to Com0H
	StateStep: assert property (@(posedge Clock) disable iff (!Reset)
		ChangeState_i |=> State == nextStateOf($past(State)))
		else $error("Scan state did not move to its successor");

	// State holds between strobes
	StateHold: assert property (@(posedge Clock) disable iff (!Reset)
		!ChangeState_i |=> State == $past(State))
		else $error("Scan state moved without a strobe");

endmodule

bind LcdScanner LcdScannerSva ScannerSva (
	.Clock         (Clock),
	.Reset         (Reset),
	.ChangeState_i (ChangeState_i),
	.State         (State),
	.LevelBus      (LevelBus)
);
`default_nettype wire

// ==== LcdClockGen.sv ====
// Testbench clock and reset source for the LCD driver
`default_nettype none
module LcdClockGen #(
	parameter int Period      = 20,          // Clock period in time units
	parameter int ResetCycles = 2            // Clocks with Reset held low
)(
	output logic Clock_o,
	output logic Reset_o
);

	initial begin
		Clock_o = 1'b0;
		Reset_o = 1'b0;                      // Active low, asserted from time 0
		repeat (ResetCycles) @(posedge Clock_o);
		#2 Reset_o = 1'b1;                   // Released with the stimulus offset
	end

	always #(Period / 2) Clock_o = ~Clock_o;

endmodule
`default_nettype wire

// ==== Lcd_tb.sv ====
// Testbench that replays bitmap vectors into the LCD driver and checks decoded pin bias levels
`default_nettype none
module Lcd_tb;

	localparam int NumVectors   = 16;        // Lines in lcd_stim.txt
	localparam int ClockPeriod  = 20;
	localparam int StateClocks  = 30;        // 1 MHz times 30 us
	localparam int SettleClocks = 6;         // Margin past a state boundary
	localparam int ChangeLimit  = 2 * StateClocks / 3; // Windows before a stuck scan
	localparam int WatchdogTime = (NumVectors + 2) * 8 * StateClocks * ClockPeriod;

	logic        Clock;
	logic        Reset;
	logic [14:0] Bitmap [0:7];               // Char 0 rightmost
	logic [36:1] Pin;

	logic [14:0] StimMem [0:8*NumVectors-1]; // Bitmap7 first on each line
	int          PinCount [1:36];            // High clocks in last window
	int          LevelSeen [0:7][1:36];      // Levels per state, current vector
	bit          SeenValid [0:7];
	int          CurState;
	bit          RunAborted = 1'b0;
	int          ErrorCount = 0;
	int          TestErrors = 0;
	int          TestCount  = 0;
	int          PassCount  = 0;
	int          FailCount  = 0;

	LcdClockGen #(
		.Period      (ClockPeriod),
		.ResetCycles (2)
	) ClockGen (
		.Clock_o (Clock),
		.Reset_o (Reset)
	);

	Lcd #(
		.ClockHz     (1_000_000),
		.ChangeComUs (30)
	) uut (
		.Clock     (Clock),
		.Reset     (Reset),
		.Bitmap7_i (Bitmap[7]),
		.Bitmap6_i (Bitmap[6]),
		.Bitmap5_i (Bitmap[5]),
		.Bitmap4_i (Bitmap[4]),
		.Bitmap3_i (Bitmap[3]),
		.Bitmap2_i (Bitmap[2]),
		.Bitmap1_i (Bitmap[1]),
		.Bitmap0_i (Bitmap[0]),
		.Pin_o     (Pin)
	);

	// Glass pin of each COM
	function automatic int comPinOf(input int C);
		case (C)
			0:       return 19;
			1:       return 36;
			2:       return 18;
			default: return 1;
		endcase
	endfunction

	function automatic int comIndexOf(input int PinNum);
		for (int C = 0; C < 4; C++)
			if (comPinOf(C) == PinNum)
				return C;
		return -1;                           // Segment pin
	endfunction

	// Pins 2-17 then 20-35
	function automatic int segIndexOf(input int PinNum);
		if (PinNum >= 2 && PinNum <= 17)
			return PinNum - 2;
		return PinNum - 4;
	endfunction

	// Bias rule and segment map
	function automatic int expectedLevel(input int PinNum, input int St);
		int C;
		int S;
		int BitIdx;
		bit Low;
		bit Lit;
		C   = St % 4;
		Low = (St >= 4);
		if (comIndexOf(PinNum) >= 0) begin
			if (comIndexOf(PinNum) == C)
				return Low ? 0 : 3;              // Active COM
			return Low ? 2 : 1;                  // Idle COM
		end
		S      = segIndexOf(PinNum);
		BitIdx = 4 * C + S % 4;
		Lit    = (BitIdx < 15) ? (Bitmap[S / 4][BitIdx] === 1'b1) : 1'b0; // No bit 15
		if (Low)
			return Lit ? 3 : 1;
		return Lit ? 0 : 2;
	endfunction

	// State from the one COM at an extreme level
	function automatic int decodeState();
		int N0;
		int N1;
		int N2;
		int N3;
		int ActiveH;
		int ActiveL;
		N0      = 0;
		N1      = 0;
		N2      = 0;
		N3      = 0;
		ActiveH = 0;
		ActiveL = 0;
		for (int C = 0; C < 4; C++) begin
			case (PinCount[comPinOf(C)])
				0: begin
					N0++;
					ActiveL = C;
				end
				1:       N1++;
				2:       N2++;
				default: begin
					N3++;
					ActiveH = C;
				end
			endcase
		end
		if (N3 == 1 && N1 == 3)
			return ActiveH;
		if (N0 == 1 && N2 == 3)
			return 4 + ActiveL;
		return -1;                           // Window crosses a boundary
	endfunction

	task automatic checkValue(input string Name, input int Expected, input int Got);
		if (Expected !== Got) begin
			ErrorCount++;
			TestErrors++;
			$display("[ERROR] time %0t, %s, expected %0d, got %0d", $time, Name, Expected, Got);
		end
	endtask

	// Three clocks give one full PWM cycle
	task automatic sampleWindow();
		for (int N = 1; N <= 36; N++)
			PinCount[N] = 0;
		repeat (3) begin
			@(negedge Clock);
			for (int N = 1; N <= 36; N++)
				PinCount[N] += int'(Pin[N]);
		end
	endtask

	// Poll until the COM pattern changes, then settle and measure
	task automatic waitNextState(input int Prev, output int Seen);
		int Tries;
		int St;
		Tries = 0;
		St    = Prev;
		Seen  = -1;
		while ((St < 0 || St == Prev) && Tries < ChangeLimit) begin
			sampleWindow();
			St = decodeState();
			Tries++;
		end
		if (St < 0 || St == Prev) begin
			ErrorCount++;
			TestErrors++;
			RunAborted = 1'b1;
			$display("Timeout at time %0t, scan left state %0d unchanged for %0d clocks",
				$time, Prev, 3 * ChangeLimit);
		end else begin
			repeat (SettleClocks) @(negedge Clock);
			sampleWindow();
			Seen = decodeState();
		end
	endtask

	// Check all pins and their DC balance against the opposite polarity
	task automatic checkState(input int St);
		for (int N = 1; N <= 36; N++) begin
			checkValue($sformatf("Pin_o[%0d]", N), expectedLevel(N, St), PinCount[N]);
			LevelSeen[St][N] = PinCount[N];
			if (SeenValid[St ^ 4])
				checkValue($sformatf("Pin_o[%0d] frame sum", N), 3,
					PinCount[N] + LevelSeen[St ^ 4][N]);
		end
		SeenValid[St] = 1'b1;
	endtask

	task automatic stepState();
		int Seen;
		waitNextState(CurState, Seen);
		if (!RunAborted) begin
			CurState = (CurState + 1) % 8;
			checkValue("scan state", CurState, Seen);
			checkState(CurState);
		end
	endtask

	task automatic applyVector(input int V);
		@(posedge Clock);
		#2;
		for (int J = 0; J < 8; J++)
			Bitmap[7 - J] = StimMem[8 * V + J];
		for (int St = 0; St < 8; St++)
			SeenValid[St] = 1'b0;              // Old levels belong to old bitmap
	endtask

	// Three windows in one state must repeat and cover all four duties
	task automatic checkDuty();
		bit [3:0] DutyMask;
		int       Seen;
		DutyMask = '0;
		waitNextState(CurState, Seen);
		if (!RunAborted) begin
			CurState = (CurState + 1) % 8;
			checkValue("scan state", CurState, Seen);
			for (int W = 0; W < 3; W++) begin
				if (W > 0)
					sampleWindow();
				for (int N = 1; N <= 36; N++) begin
					checkValue($sformatf("Pin_o[%0d] duty", N), expectedLevel(N, CurState),
						PinCount[N]);
					DutyMask[PinCount[N] % 4] = 1'b1;
				end
			end
			for (int K = 0; K < 4; K++)
				checkValue($sformatf("duty %0d of 3 present", K), 1, int'(DutyMask[K]));
		end
	endtask

	task automatic finishTest(input string Name);
		TestCount++;
		if (TestErrors == 0) begin
			PassCount++;
			$display("Test %0d %s: pass", TestCount, Name);
		end else begin
			FailCount++;
			$display("Test %0d %s: FAIL with %0d errors", TestCount, Name, TestErrors);
		end
		TestErrors = 0;
	endtask

	initial begin : Main
		int Seen;
		for (int J = 0; J < 8; J++)
			Bitmap[J] = '0;
		for (int St = 0; St < 8; St++)
			SeenValid[St] = 1'b0;
		CurState = 0;
		$readmemh("lcd_stim.txt", StimMem);
		if ($isunknown(StimMem[8 * NumVectors - 1])) begin
			$display("Stim file lcd_stim.txt is missing or holds fewer than %0d vectors",
				NumVectors);
			ErrorCount++;
			FailCount++;
			RunAborted = 1'b1;
		end
		wait (Reset === 1'b1);
		if (!RunAborted) begin
			repeat (4) @(negedge Clock);
			sampleWindow();
			Seen = decodeState();
			checkValue("scan state", 0, Seen); // Com0H first
			checkState(0);
			finishTest("reset state Com0H");
		end
		for (int V = 0; V < NumVectors && !RunAborted; V++) begin
			applyVector(V);
			for (int K = 0; K < 8 && !RunAborted; K++)
				stepState();                     // One whole frame per vector
			finishTest($sformatf("vector %0d", V));
		end
		if (!RunAborted) begin
			checkDuty();
			finishTest("PWM duty");
		end
		$display("Tests %0d, passed %0d, failed %0d, mismatches %0d",
			TestCount, PassCount, FailCount, ErrorCount);
		if (ErrorCount == 0 && FailCount == 0 && !RunAborted)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Whole run bounded by vector count plus margin
	initial begin : Watchdog
		#(WatchdogTime);
		$display("Watchdog timeout after %0d time units, the tests did not finish",
			WatchdogTime);
		$display("Regression failed");
		$finish;
	end

endmodule
`default_nettype wire

// ==== lcd_stim.txt ====
// Columns: Bitmap7 Bitmap6 Bitmap5 Bitmap4 Bitmap3 Bitmap2 Bitmap1 Bitmap0
// 15-bit hex bitmaps, segment order pnmlkjihgfedcba, character 0 rightmost
0000 0000 0000 0000 0000 0000 0000 0000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
0001 0002 0004 0008 0010 0020 0040 0080
0100 0200 0400 0800 1000 2000 4000 0001
4000 2000 1000 0800 0400 0200 0100 0080
0040 0020 0010 0008 0004 0002 0001 4000
5555 2AAA 5555 2AAA 5555 2AAA 5555 2AAA
2AAA 5555 2AAA 5555 2AAA 5555 2AAA 5555
70F0 0F0F 70F0 0F0F 70F0 0F0F 70F0 0F0F
1234 5678 1ABC 2DEF 3210 4567 0ACE 7BDF
7FFF 0000 7FFF 0000 0000 7FFF 0000 7FFF
00FF 7F00 0F0F 70F0 3333 4CCC 1111 6666
0421 0842 1084 2108 4210 0001 7FFE 3C3C
0000 0000 0000 0001 0000 0000 0000 0000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFE
6B5A 1C3E 2F41 3D97 0E6C 5A21 47B8 19F0

// ==== sources.f ====
LcdPkg.sv
LcdLevelIf.sv
StrobeGenerator.sv
LcdPwm.sv
LcdScanner.sv
Lcd.sv
Lcd_sva.sv
LcdClockGen.sv
Lcd_tb.sv

// ==== Makefile ====
# Verilator build and regression run for the LCD driver

VERILATOR ?= verilator
TOP       ?= Lcd_tb
FILELIST  ?= sources.f
STIM      ?= lcd_stim.txt
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIMEXE  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMEXE)

$(SIMEXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Fails on a nonzero exit or when the log reports a failed regression
run: compile $(STIM)
	./$(SIMEXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG) || \
		! grep -q "Regression passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
